/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_bus_subsystem
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then \
		echo "simulation result: FAIL"; exit 1; \
	elif ! grep -q "all tests passed" $(LOG); then \
		echo "simulation result: no pass message in $(LOG)"; exit 1; \
	else \
		echo "simulation result: PASS"; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/bus_protocol_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_protocol_sva (
    input  wire logic                          clk,
    input  wire logic                          arst_n,
    input  bus_pkg::bus_m2s_t                  m2s_in [bus_pkg::N_MASTERS],
    input  wire logic [bus_pkg::N_MASTERS-1:0] grant
);

    a_grant_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(grant))
        else $error("more than one master granted, grant %b", grant);

    for (genvar i = 0; i < bus_pkg::N_MASTERS; i++) begin : g_master
        // owner keeps the bus as long as it requests
        a_grant_held: assert property (@(posedge clk) disable iff (!arst_n)
            grant[i] && m2s_in[i].req |=> grant[i])
            else $error("grant of master %0d dropped while it still requests", i);

        a_addr_granted: assert property (@(posedge clk) disable iff (!arst_n)
            m2s_in[i].addr_phase |-> grant[i])
            else $error("master %0d in address phase without grant", i);
    end

endmodule

`default_nettype wire

/* bench/bus_trace.txt */
# C port write addr len word0 word1 word2 word3 is a command, len is beats minus one, all hex
# R port write len word0 word1 word2 word3 is an expected response, D waits for all responses
C 0 1 0010 0 cafe0001 0 0 0
R 0 1 0 0 0 0 0
C 1 1 0080 3 11110000 11110001 11110002 11110003
R 1 1 3 0 0 0 0
C 0 1 0020 1 a0000020 a0000021 deadbeef deadbeef
R 0 1 1 0 0 0 0
C 1 1 0090 2 b0000090 b0000091 b0000092 deadbeef
R 1 1 2 0 0 0 0
C 0 1 00fe 3 e00000fe e00000ff e0000000 e0000001
R 0 1 3 0 0 0 0
D
C 0 0 0010 0 0 0 0 0
R 0 0 0 cafe0001 0 0 0
C 1 0 0080 3 0 0 0 0
R 1 0 3 11110000 11110001 11110002 11110003
C 0 0 0020 1 0 0 0 0
R 0 0 1 a0000020 a0000021 0 0
C 1 0 0090 2 0 0 0 0
R 1 0 2 b0000090 b0000091 b0000092 0
C 0 0 0000 1 0 0 0 0
R 0 0 1 e0000000 e0000001 0 0
C 1 0 0083 0 0 0 0 0
R 1 0 0 11110003 0 0 0

/* bench/tb_bus_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_bus_subsystem;

    localparam int MAX_ITEMS    = 64;
    localparam int MAX_PHASES   = 16;
    localparam int RESET_CYCLES = 16;
    localparam int NEWLINE      = 10;

    logic              clk;
    logic              arst_n;
    logic [1:0]        cmd_valid;
    logic [1:0]        cmd_ready;
    bus_pkg::bus_cmd_t cmd_data [2];
    logic [1:0]        rsp_valid;
    logic [1:0]        rsp_ready;
    bus_pkg::bus_rsp_t rsp_data [2];

    bus_pkg::bus_cmd_t cmd_list   [MAX_ITEMS];
    int                cmd_port   [MAX_ITEMS];
    int                cmd_phase  [MAX_ITEMS];
    bus_pkg::bus_rsp_t exp_list   [MAX_ITEMS];
    int                exp_port   [MAX_ITEMS];
    int                drain_need [MAX_PHASES][2];   // responses owed per port before a phase
    int                exp_total  [2];
    int                rsp_count  [2];
    int                n_cmds;
    int                n_exps;
    int                n_lines;
    int                mismatch_count;
    int                fault_count;
    bit                trace_ok;
    bit                trace_loaded;
    int                seed = 32'h6bc1a031;

    bus_subsystem_top u_bus_subsystem_top (
        .clk(clk), .arst_n(arst_n),
        .cmd0_valid(cmd_valid[0]), .cmd0_ready(cmd_ready[0]), .cmd0(cmd_data[0]),
        .cmd1_valid(cmd_valid[1]), .cmd1_ready(cmd_ready[1]), .cmd1(cmd_data[1]),
        .rsp0_valid(rsp_valid[0]), .rsp0_ready(rsp_ready[0]), .rsp0(rsp_data[0]),
        .rsp1_valid(rsp_valid[1]), .rsp1_ready(rsp_ready[1]), .rsp1(rsp_data[1])
    );

    bind bus_arbiter bus_protocol_sva u_protocol_sva (
        .clk(clk), .arst_n(arst_n), .m2s_in(m2s_in), .grant(grant)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_rsp(input string name, input bus_pkg::bus_rsp_t expected,
                             input bus_pkg::bus_rsp_t actual);
        if (actual !== expected) begin
            $display("FAILED %0t %s expected %h actual %h", $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          ch;
        int          cnt;
        int          phase;
        logic [7:0]  tag;
        logic [31:0] port, we, addr, len, w0, w1, w2, w3;
        phase = 0;
        fd = $fopen("bench/bus_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file bench/bus_trace.txt");
            trace_ok = 1'b0;
            return;
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                ch = $fgetc(fd);
                while (ch != NEWLINE && ch != -1) ch = $fgetc(fd);   // rest of comment
            end else if (tag == "C") begin
                cnt = $fscanf(fd, "%h %h %h %h %h %h %h %h", port, we, addr, len,
                              w0, w1, w2, w3);
                if (cnt != 8 || port > 1) trace_ok = 1'b0;
                cmd_list[n_cmds].write = we[0];
                cmd_list[n_cmds].addr  = addr[bus_pkg::ADDR_W-1:0];
                cmd_list[n_cmds].len   = len[bus_pkg::LEN_W-1:0];
                cmd_list[n_cmds].data  = {w3, w2, w1, w0};
                cmd_port[n_cmds]       = int'(port);
                cmd_phase[n_cmds]      = phase;
                n_cmds++;
                n_lines++;
            end else if (tag == "R") begin
                cnt = $fscanf(fd, "%h %h %h %h %h %h %h", port, we, len, w0, w1, w2, w3);
                if (cnt != 7 || port > 1) trace_ok = 1'b0;
                exp_list[n_exps].write = we[0];
                exp_list[n_exps].len   = len[bus_pkg::LEN_W-1:0];
                exp_list[n_exps].data  = {w3, w2, w1, w0};
                exp_port[n_exps]       = int'(port);
                exp_total[port[0]]++;
                n_exps++;
                n_lines++;
            end else if (tag == "D") begin
                drain_need[phase][0] = exp_total[0];
                drain_need[phase][1] = exp_total[1];
                phase++;
                n_lines++;
            end else begin
                trace_ok = 1'b0;
            end
        end
        $fclose(fd);
        if (!trace_ok) $display("the trace file holds a malformed line");
    endtask

    function automatic bit drain_done(input int phase);
        if (phase == 0) return 1'b1;
        return rsp_count[0] >= drain_need[phase-1][0] && rsp_count[1] >= drain_need[phase-1][1];
    endfunction

    // called 1 ns after a rising edge
    task automatic drive_commands(input int port);
        for (int i = 0; i < n_cmds; i++) begin
            if (cmd_port[i] != port) continue;
            while (!drain_done(cmd_phase[i])) begin
                @(posedge clk);
                #1;
            end
            cmd_valid[port] = 1'b1;
            cmd_data[port]  = cmd_list[i];
            @(negedge clk);
            while (!cmd_ready[port]) @(negedge clk);
            @(posedge clk);
            #1;
            cmd_valid[port] = 1'b0;
        end
    endtask

    task automatic check_responses(input int port);
        bus_pkg::bus_rsp_t held;
        bit                stalled;
        stalled = 1'b0;
        held    = '0;
        for (int i = 0; i < n_exps; i++) begin
            if (exp_port[i] != port) continue;
            forever begin
                @(negedge clk);
                if (stalled) begin
                    if (!rsp_valid[port]) begin
                        $display("response valid on port %0d dropped before acceptance", port);
                        fault_count++;
                    end
                    check_rsp($sformatf("rsp%0d (stalled)", port), held, rsp_data[port]);
                end
                if (rsp_valid[port] && rsp_ready[port]) break;
                stalled = rsp_valid[port];
                held    = rsp_data[port];
            end
            stalled = 1'b0;
            check_rsp($sformatf("rsp%0d", port), exp_list[i], rsp_data[port]);
            rsp_count[port]++;
        end
    endtask

    // random response back-pressure with ready about 3 cycles in 4
    initial begin
        logic [31:0] r;
        rsp_ready = 2'b00;
        @(posedge arst_n);
        forever begin
            @(posedge clk);
            #1;
            r = $random(seed);
            rsp_ready[0] = (r[1:0] != 2'b00);
            rsp_ready[1] = (r[3:2] != 2'b00);
        end
    end

    initial begin : watchdog
        int limit;
        wait (trace_loaded);
        limit = n_lines * 100 + 1000;
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles, responses never arrived", limit);
        $display("tests failed");
        $finish;
    end

    initial begin
        int extra;
        arst_n         = 1'b0;
        cmd_valid      = 2'b00;
        cmd_data[0]    = '0;
        cmd_data[1]    = '0;
        rsp_count      = '{0, 0};
        exp_total      = '{0, 0};
        n_cmds         = 0;
        n_exps         = 0;
        n_lines        = 0;
        mismatch_count = 0;
        fault_count    = 0;
        extra          = 0;
        trace_ok       = 1'b1;
        load_trace();
        trace_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
        if (trace_ok) begin
            fork
                drive_commands(0);
                drive_commands(1);
                check_responses(0);
                check_responses(1);
            join
            repeat (20) begin   // nothing may follow the last expected response
                @(negedge clk);
                if ((rsp_valid & rsp_ready) != 2'b00) extra++;
            end
            if (extra != 0) $display("%0d responses arrived beyond the trace", extra);
            fault_count += extra;
        end else begin
            fault_count++;
        end
        $display("summary: %0d data mismatches, %0d other errors", mismatch_count, fault_count);
        if (mismatch_count == 0 && fault_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/bus_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter (
    input  wire logic                         clk,
    input  wire logic                         arst_n,
    input  bus_pkg::bus_m2s_t                 m2s_in [bus_pkg::N_MASTERS],
    output logic [bus_pkg::N_MASTERS-1:0]     grant,
    output bus_pkg::bus_m2s_t                 m2s_out
);

    logic [bus_pkg::N_MASTERS-1:0]    grant_q;
    logic [bus_pkg::MASTER_IDX_W-1:0] last_q;   // last winner and owner while held
    logic [bus_pkg::MASTER_IDX_W-1:0] pick;
    logic                             pick_valid;
    logic                             held;

    assign held  = |grant_q;
    assign grant = grant_q;

    // lowest offset from last winner has priority
    always_comb begin
        int cand;
        pick       = last_q;
        pick_valid = 1'b0;
        for (int i = bus_pkg::N_MASTERS; i >= 1; i--) begin
            cand = (int'(last_q) + i) % bus_pkg::N_MASTERS;
            if (m2s_in[cand].req) begin
                pick       = cand[bus_pkg::MASTER_IDX_W-1:0];
                pick_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            grant_q <= '0;
            last_q  <= bus_pkg::LAST_INIT;   // master 0 wins first tie
        end else if (!held) begin
            if (pick_valid) begin
                grant_q[pick] <= 1'b1;
                last_q        <= pick;
            end
        end else if (!m2s_in[last_q].req) begin
            grant_q <= '0;
        end
    end

    assign m2s_out = held ? m2s_in[last_q] : '0;

endmodule

`default_nettype wire

/* design/bus_master.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_master (
    input  wire logic              clk,
    input  wire logic              arst_n,

    input  wire logic              cmd_valid,
    output logic                   cmd_ready,
    input  bus_pkg::bus_cmd_t      cmd,

    output logic                   rsp_valid,
    input  wire logic              rsp_ready,
    output bus_pkg::bus_rsp_t      rsp,

    output bus_pkg::bus_m2s_t      m2s,
    input  wire logic              grant,
    input  bus_pkg::bus_s2m_t      s2m
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REQ,
        ST_ADDR,
        ST_WAIT,
        ST_DATA,
        ST_FINISH
    } state_t;

    state_t state_q;
    state_t state_d;

    bus_pkg::bus_cmd_t                                cmd_q;
    logic [bus_pkg::LEN_W-1:0]                        beat_q;
    logic [bus_pkg::BURST_MAX-1:0][bus_pkg::DATA_W-1:0] rd_q;
    logic                                             beat;
    logic                                             last_beat;

    // first beat can land in the wait state once wait drops
    assign beat      = (state_q == ST_DATA) || (state_q == ST_WAIT && !s2m.slv_wait);
    assign last_beat = beat && (beat_q == cmd_q.len);

    assign cmd_ready = (state_q == ST_IDLE);
    assign rsp_valid = (state_q == ST_FINISH);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (cmd_valid) state_d = ST_REQ;
            end
            ST_REQ: begin
                if (grant) state_d = ST_ADDR;
            end
            ST_ADDR: begin
                state_d = ST_WAIT;
            end
            ST_WAIT: begin
                if (!s2m.slv_wait) state_d = last_beat ? ST_FINISH : ST_DATA;
            end
            ST_DATA: begin
                if (last_beat) state_d = ST_FINISH;
            end
            ST_FINISH: begin
                if (rsp_ready) state_d = ST_IDLE;   // else hold grant until room
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ST_IDLE;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            if (beat) beat_q <= last_beat ? '0 : beat_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            cmd_q <= cmd;
        end
        if (beat && !cmd_q.write) begin
            rd_q[beat_q] <= s2m.rdata;   // read word into its slot
        end
    end

    always_comb begin
        m2s            = '0;
        m2s.req        = (state_q == ST_REQ) || (state_q == ST_ADDR) ||
                         (state_q == ST_WAIT) || (state_q == ST_DATA) ||
                         (state_q == ST_FINISH && !rsp_ready);
        m2s.we         = cmd_q.write;
        m2s.len        = cmd_q.len;
        m2s.addr_phase = (state_q == ST_ADDR);
        if (state_q == ST_ADDR) begin
            m2s.data = {{(bus_pkg::DATA_W - bus_pkg::ADDR_W){1'b0}}, cmd_q.addr};
        end else begin
            m2s.data = cmd_q.data[beat_q];
        end
    end

    // one response per command with data masked to the burst
    always_comb begin
        rsp       = '0;
        rsp.write = cmd_q.write;
        rsp.len   = cmd_q.len;
        for (int i = 0; i < bus_pkg::BURST_MAX; i++) begin
            if (!cmd_q.write && i <= int'(cmd_q.len)) begin
                rsp.data[i] = rd_q[i];
            end
        end
    end

endmodule

`default_nettype wire

/* design/bus_memory_slave.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_memory_slave (
    input  wire logic          clk,
    input  wire logic          arst_n,
    input  bus_pkg::bus_m2s_t  m2s,
    output bus_pkg::bus_s2m_t  s2m
);

    logic [bus_pkg::DATA_W-1:0] mem [bus_pkg::MEM_WORDS];

    logic [bus_pkg::MEM_AW-1:0] addr_q;   // wraps at MEM_WORDS
    logic                       we_q;
    logic [bus_pkg::LEN_W-1:0]  len_q;
    logic [bus_pkg::LEN_W-1:0]  beat_q;
    logic [bus_pkg::WAIT_W-1:0] wait_q;
    logic                       busy_q;
    logic                       beat;

    assign beat         = busy_q && (wait_q == '0);
    assign s2m.slv_wait = (wait_q != '0);
    assign s2m.rdata    = mem[addr_q];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= 1'b0;
            wait_q <= '0;
            beat_q <= '0;
        end else if (m2s.addr_phase) begin
            busy_q <= 1'b1;
            wait_q <= bus_pkg::WAIT_INIT;
            beat_q <= '0;
        end else if (wait_q != '0) begin
            wait_q <= wait_q - 1'b1;
        end else if (beat) begin
            beat_q <= beat_q + 1'b1;
            if (beat_q == len_q) busy_q <= 1'b0;   // last beat
        end
    end

    always_ff @(posedge clk) begin
        if (m2s.addr_phase) begin
            addr_q <= m2s.data[bus_pkg::MEM_AW-1:0];
            we_q   <= m2s.we;
            len_q  <= m2s.len;
        end else if (beat) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat && we_q) begin
            mem[addr_q] <= m2s.data;
        end
    end

endmodule

`default_nettype wire

/* design/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    localparam int ADDR_W            = 16;
    localparam int DATA_W            = 32;
    localparam int BURST_MAX         = 4;
    localparam int LEN_W             = $clog2(BURST_MAX);   // beats minus one
    localparam int MEM_WORDS         = 256;
    localparam int MEM_AW            = $clog2(MEM_WORDS);
    localparam int SLAVE_WAIT_CYCLES = 2;
    localparam int WAIT_W            = $clog2(SLAVE_WAIT_CYCLES + 1);
    localparam int N_MASTERS         = 2;
    localparam int MASTER_IDX_W      = $clog2(N_MASTERS);

    localparam logic [WAIT_W-1:0]       WAIT_INIT = WAIT_W'(SLAVE_WAIT_CYCLES);
    localparam logic [MASTER_IDX_W-1:0] LAST_INIT = MASTER_IDX_W'(N_MASTERS - 1);

    // 147 bits
    typedef struct packed {
        logic                             write;
        logic [ADDR_W-1:0]                addr;
        logic [LEN_W-1:0]                 len;
        logic [BURST_MAX-1:0][DATA_W-1:0] data;   // only len+1 words used on write
    } bus_cmd_t;

    typedef struct packed {
        logic                             write;
        logic [LEN_W-1:0]                 len;
        logic [BURST_MAX-1:0][DATA_W-1:0] data;   // zero past the burst and all zero on write
    } bus_rsp_t;

    typedef struct packed {
        logic              req;
        logic [DATA_W-1:0] data;         // address in address phase, else write word
        logic              we;
        logic [LEN_W-1:0]  len;
        logic              addr_phase;
    } bus_m2s_t;

    typedef struct packed {
        logic              slv_wait;
        logic [DATA_W-1:0] rdata;
    } bus_s2m_t;

endpackage

`default_nettype wire

/* design/bus_subsystem_top.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_subsystem_top (
    input  wire logic          clk,
    input  wire logic          arst_n,

    input  wire logic          cmd0_valid,
    output logic               cmd0_ready,
    input  bus_pkg::bus_cmd_t  cmd0,
    input  wire logic          cmd1_valid,
    output logic               cmd1_ready,
    input  bus_pkg::bus_cmd_t  cmd1,

    output logic               rsp0_valid,
    input  wire logic          rsp0_ready,
    output bus_pkg::bus_rsp_t  rsp0,
    output logic               rsp1_valid,
    input  wire logic          rsp1_ready,
    output bus_pkg::bus_rsp_t  rsp1
);

    logic [bus_pkg::N_MASTERS-1:0] port_cmd_valid;
    logic [bus_pkg::N_MASTERS-1:0] port_cmd_ready;
    bus_pkg::bus_cmd_t             port_cmd [bus_pkg::N_MASTERS];
    logic [bus_pkg::N_MASTERS-1:0] port_rsp_valid;
    logic [bus_pkg::N_MASTERS-1:0] port_rsp_ready;
    bus_pkg::bus_rsp_t             port_rsp [bus_pkg::N_MASTERS];

    logic [bus_pkg::N_MASTERS-1:0] q_cmd_valid;
    logic [bus_pkg::N_MASTERS-1:0] q_cmd_ready;
    bus_pkg::bus_cmd_t             q_cmd [bus_pkg::N_MASTERS];
    logic [bus_pkg::N_MASTERS-1:0] m_rsp_valid;
    logic [bus_pkg::N_MASTERS-1:0] m_rsp_ready;
    bus_pkg::bus_rsp_t             m_rsp [bus_pkg::N_MASTERS];

    bus_pkg::bus_m2s_t             m2s [bus_pkg::N_MASTERS];
    logic [bus_pkg::N_MASTERS-1:0] grant;
    bus_pkg::bus_m2s_t             slv_m2s;
    bus_pkg::bus_s2m_t             s2m;   // shared by both masters

    assign port_cmd_valid = {cmd1_valid, cmd0_valid};
    assign {cmd1_ready, cmd0_ready} = port_cmd_ready;
    assign port_cmd[0] = cmd0;
    assign port_cmd[1] = cmd1;
    assign {rsp1_valid, rsp0_valid} = port_rsp_valid;
    assign port_rsp_ready = {rsp1_ready, rsp0_ready};
    assign rsp0 = port_rsp[0];
    assign rsp1 = port_rsp[1];

    for (genvar i = 0; i < bus_pkg::N_MASTERS; i++) begin : g_chain
        stage_queue #(.payload_t(bus_pkg::bus_cmd_t)) u_cmd_queue (
            .clk(clk), .arst_n(arst_n),
            .in_valid(port_cmd_valid[i]), .in_ready(port_cmd_ready[i]), .in_data(port_cmd[i]),
            .out_valid(q_cmd_valid[i]), .out_ready(q_cmd_ready[i]), .out_data(q_cmd[i])
        );

        bus_master u_master (
            .clk(clk), .arst_n(arst_n),
            .cmd_valid(q_cmd_valid[i]), .cmd_ready(q_cmd_ready[i]), .cmd(q_cmd[i]),
            .rsp_valid(m_rsp_valid[i]), .rsp_ready(m_rsp_ready[i]), .rsp(m_rsp[i]),
            .m2s(m2s[i]), .grant(grant[i]), .s2m(s2m)
        );

        stage_queue #(.payload_t(bus_pkg::bus_rsp_t)) u_rsp_queue (
            .clk(clk), .arst_n(arst_n),
            .in_valid(m_rsp_valid[i]), .in_ready(m_rsp_ready[i]), .in_data(m_rsp[i]),
            .out_valid(port_rsp_valid[i]), .out_ready(port_rsp_ready[i]), .out_data(port_rsp[i])
        );
    end

    bus_arbiter u_arbiter (
        .clk(clk), .arst_n(arst_n),
        .m2s_in(m2s), .grant(grant), .m2s_out(slv_m2s)
    );

    bus_memory_slave u_slave (
        .clk(clk), .arst_n(arst_n),
        .m2s(slv_m2s), .s2m(s2m)
    );

endmodule

`default_nettype wire

/* design/stage_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module stage_queue #(
    parameter type payload_t = logic
) (
    input  wire logic clk,
    input  wire logic arst_n,

    input  wire logic in_valid,
    output logic      in_ready,
    input  payload_t  in_data,

    output logic      out_valid,
    input  wire logic out_ready,
    output payload_t  out_data
);

    payload_t   slots [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = slots[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) wr_ptr <= ~wr_ptr;
            if (pop) rd_ptr <= ~rd_ptr;
            if (push && !pop) count <= count + 2'd1;
            else if (pop && !push) count <= count - 2'd1;
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
design/bus_pkg.sv
design/stage_queue.sv
design/bus_master.sv
design/bus_arbiter.sv
design/bus_memory_slave.sv
design/bus_subsystem_top.sv
bench/bus_protocol_sva.sv
bench/tb_bus_subsystem.sv
